// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_core_top
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= NO ERRORS

SOURCES := $(wildcard logic/*.sv logic/*.svh tests/*.sv tests/*.svh) vlog.f
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f vlog.f

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// ==== logic/alu_execute.sv ====
/*
 * ALU: add, subtract, logic ops and signed set-less-than
 * on rs1 and either rs2 or the immediate
 */

`timescale 1ns/1ns
`default_nettype none

`include "core_defines.svh"

module alu_execute (
  input  logic [`CORE_XLEN-1:0] rs1_data_i,
  input  logic [`CORE_XLEN-1:0] rs2_data_i,
  input  logic [`CORE_XLEN-1:0] imm_i,
  input  logic                  use_imm_i,
  input  core_pkg::alu_op_e     alu_op_i,
  output logic [`CORE_XLEN-1:0] result_o
);

  import core_pkg::*;

  logic [`CORE_XLEN-1:0] operand_b;
  logic                  less_than;

  assign operand_b = use_imm_i ? imm_i : rs2_data_i;
  assign less_than = $signed(rs1_data_i) < $signed(operand_b);

  always_comb begin
    case (alu_op_i)
      ALU_ADD: result_o = rs1_data_i + operand_b;
      ALU_SUB: result_o = rs1_data_i - operand_b;
      ALU_AND: result_o = rs1_data_i & operand_b;
      ALU_OR:  result_o = rs1_data_i | operand_b;
      ALU_XOR: result_o = rs1_data_i ^ operand_b;
      ALU_SLT: result_o = {{(`CORE_XLEN-1){1'b0}}, less_than};
      default: result_o = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== logic/core_defines.svh ====
/*
 * Core constants: data and register widths, RV32I opcodes,
 * function codes and the WFI encoding
 */

`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

`define CORE_XLEN        32
`define CORE_REG_AW      5
`define CORE_NUM_REGS    32

// Major opcodes
`define CORE_OPC_OP      7'b0110011
`define CORE_OPC_OP_IMM  7'b0010011
`define CORE_OPC_SYSTEM  7'b1110011

`define CORE_F3_ADD      3'b000
`define CORE_F3_SLT      3'b010
`define CORE_F3_XOR      3'b100
`define CORE_F3_OR       3'b110
`define CORE_F3_AND      3'b111
`define CORE_F7_SUB      7'b0100000

`define CORE_INSTR_WFI   32'h10500073

`endif

// ==== logic/core_pkg.sv ====
/*
 * Core types: the two views of a fetched instruction word
 * and the ALU operation select
 */

`default_nettype none

`include "core_defines.svh"

package core_pkg;

  // Register-register view
  typedef struct packed {
    logic [6:0]              funct7;
    logic [`CORE_REG_AW-1:0] rs2;
    logic [`CORE_REG_AW-1:0] rs1;
    logic [2:0]              funct3;
    logic [`CORE_REG_AW-1:0] rd;
    logic [6:0]              opcode;
  } instr_r_t;

  // Register-immediate view
  typedef struct packed {
    logic [11:0]             imm;
    logic [`CORE_REG_AW-1:0] rs1;
    logic [2:0]              funct3;
    logic [`CORE_REG_AW-1:0] rd;
    logic [6:0]              opcode;
  } instr_i_t;

  typedef union packed {
    instr_r_t r;
    instr_i_t i;
  } instr_u;

  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_XOR = 3'd4,
    ALU_SLT = 3'd5
  } alu_op_e;

endpackage

`default_nettype wire

// ==== logic/core_top.sv ====
/*
 * Core top level: sleep controller with fetch, decode,
 * execute and result stages
 */

`timescale 1ns/1ns
`default_nettype none

`include "core_defines.svh"

module core_top (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    fetch_enable_i,
  input  logic [`CORE_XLEN-1:0]   boot_addr_i,
  input  logic                    irq_i,
  input  logic                    instr_gnt_i,
  input  logic                    instr_rvalid_i,
  input  logic [`CORE_XLEN-1:0]   instr_rdata_i,
  output logic                    instr_req_o,
  output logic [`CORE_XLEN-1:0]   instr_addr_o,
  output logic                    core_sleep_o,
  output logic                    retire_valid_o,
  output logic [`CORE_XLEN-1:0]   retire_pc_o,
  output logic [`CORE_XLEN-1:0]   retire_instr_o,
  output logic [`CORE_REG_AW-1:0] retire_rd_o,
  output logic [`CORE_XLEN-1:0]   retire_wdata_o
);

  import core_pkg::*;

  logic                    core_en;
  logic                    wfi_retire;
  logic                    retire_done;
  instr_u                  instr_word;
  logic                    instr_valid;
  logic [`CORE_XLEN-1:0]   pc;
  logic [`CORE_REG_AW-1:0] rs1_addr;
  logic [`CORE_REG_AW-1:0] rs2_addr;
  logic [`CORE_REG_AW-1:0] rd_addr;
  logic [`CORE_XLEN-1:0]   imm;
  logic                    use_imm;
  alu_op_e                 alu_op;
  logic                    legal;
  logic                    wfi;
  logic [`CORE_XLEN-1:0]   rs1_data;
  logic [`CORE_XLEN-1:0]   rs2_data;
  logic [`CORE_XLEN-1:0]   result;

  ////////////////////////////////////////////////////////////////////////////
  // Clock enable
  ////////////////////////////////////////////////////////////////////////////

  sleep_ctrl i_sleep_ctrl (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .fetch_enable_i (fetch_enable_i),
    .irq_i          (irq_i),
    .wfi_retire_i   (wfi_retire),
    .core_en_o      (core_en),
    .core_sleep_o   (core_sleep_o)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Core stages
  ////////////////////////////////////////////////////////////////////////////

  instr_fetch i_instr_fetch (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .core_en_i      (core_en),
    .boot_addr_i    (boot_addr_i),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i),
    .retire_done_i  (retire_done),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .instr_word_o   (instr_word),
    .instr_valid_o  (instr_valid),
    .pc_o           (pc)
  );

  instr_decode i_instr_decode (
    .instr_word_i (instr_word),
    .rs1_addr_o   (rs1_addr),
    .rs2_addr_o   (rs2_addr),
    .rd_addr_o    (rd_addr),
    .imm_o        (imm),
    .use_imm_o    (use_imm),
    .alu_op_o     (alu_op),
    .legal_o      (legal),
    .wfi_o        (wfi)
  );

  alu_execute i_alu_execute (
    .rs1_data_i (rs1_data),
    .rs2_data_i (rs2_data),
    .imm_i      (imm),
    .use_imm_i  (use_imm),
    .alu_op_i   (alu_op),
    .result_o   (result)
  );

  reg_result i_reg_result (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .core_en_i      (core_en),
    .instr_valid_i  (instr_valid),
    .instr_word_i   (instr_word),
    .pc_i           (pc),
    .rs1_addr_i     (rs1_addr),
    .rs2_addr_i     (rs2_addr),
    .rd_addr_i      (rd_addr),
    .result_i       (result),
    .legal_i        (legal),
    .wfi_i          (wfi),
    .rs1_data_o     (rs1_data),
    .rs2_data_o     (rs2_data),
    .retire_done_o  (retire_done),
    .wfi_retire_o   (wfi_retire),
    .retire_valid_o (retire_valid_o),
    .retire_pc_o    (retire_pc_o),
    .retire_instr_o (retire_instr_o),
    .retire_rd_o    (retire_rd_o),
    .retire_wdata_o (retire_wdata_o)
  );

endmodule

`default_nettype wire

// ==== logic/instr_decode.sv ====
/*
 * Instruction decoder producing register addresses, the sign-extended
 * immediate, the ALU operation and the WFI and legal flags
 */

`timescale 1ns/1ns
`default_nettype none

`include "core_defines.svh"

module instr_decode (
  input  core_pkg::instr_u        instr_word_i,
  output logic [`CORE_REG_AW-1:0] rs1_addr_o,
  output logic [`CORE_REG_AW-1:0] rs2_addr_o,
  output logic [`CORE_REG_AW-1:0] rd_addr_o,
  output logic [`CORE_XLEN-1:0]   imm_o,
  output logic                    use_imm_o,
  output core_pkg::alu_op_e       alu_op_o,
  output logic                    legal_o,
  output logic                    wfi_o
);

  import core_pkg::*;

  logic [6:0] opcode;
  logic [6:0] funct7;
  logic [2:0] funct3;

  assign opcode = instr_word_i.r.opcode;
  assign funct7 = instr_word_i.r.funct7;
  assign funct3 = instr_word_i.r.funct3;

  always_comb begin
    rs1_addr_o = instr_word_i.r.rs1;
    rs2_addr_o = instr_word_i.r.rs2;
    rd_addr_o  = instr_word_i.r.rd;
    imm_o      = {{(`CORE_XLEN-12){instr_word_i.i.imm[11]}}, instr_word_i.i.imm};
    use_imm_o  = 1'b0;
    alu_op_o   = ALU_ADD;
    legal_o    = 1'b0;
    wfi_o      = 1'b0;

    case (opcode)
      `CORE_OPC_OP: begin
        legal_o = (funct7 == 7'b0);
        case (funct3)
          `CORE_F3_ADD: begin
            if (funct7 == `CORE_F7_SUB) begin
              alu_op_o = ALU_SUB;
              legal_o  = 1'b1;
            end
          end
          `CORE_F3_XOR: alu_op_o = ALU_XOR;
          `CORE_F3_OR:  alu_op_o = ALU_OR;
          `CORE_F3_AND: alu_op_o = ALU_AND;
          `CORE_F3_SLT: alu_op_o = ALU_SLT;
          default:      legal_o  = 1'b0;
        endcase
      end
      `CORE_OPC_OP_IMM: begin
        // Immediate view where the rs2 field belongs to the immediate
        use_imm_o  = 1'b1;
        legal_o    = 1'b1;
        case (instr_word_i.i.funct3)
          `CORE_F3_ADD: alu_op_o = ALU_ADD;
          `CORE_F3_XOR: alu_op_o = ALU_XOR;
          `CORE_F3_OR:  alu_op_o = ALU_OR;
          `CORE_F3_AND: alu_op_o = ALU_AND;
          default:      legal_o  = 1'b0;
        endcase
      end
      `CORE_OPC_SYSTEM: begin
        // Only the exact WFI word
        wfi_o   = (instr_word_i == `CORE_INSTR_WFI);
        legal_o = wfi_o;
      end
      default: legal_o = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

// ==== logic/instr_fetch.sv ====
/*
 * Instruction fetch: program counter and the request, grant and
 * read-valid sequencing towards instruction memory
 */

`timescale 1ns/1ns
`default_nettype none

`include "core_defines.svh"

module instr_fetch (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  core_en_i,
  input  logic [`CORE_XLEN-1:0] boot_addr_i,
  input  logic                  instr_gnt_i,
  input  logic                  instr_rvalid_i,
  input  logic [`CORE_XLEN-1:0] instr_rdata_i,
  input  logic                  retire_done_i,
  output logic                  instr_req_o,
  output logic [`CORE_XLEN-1:0] instr_addr_o,
  output core_pkg::instr_u      instr_word_o,
  output logic                  instr_valid_o,
  output logic [`CORE_XLEN-1:0] pc_o
);

  localparam logic [1:0] StReq        = 2'd0;
  localparam logic [1:0] StWaitData   = 2'd1;
  localparam logic [1:0] StWaitRetire = 2'd2;

  logic [1:0]            state_q, state_d;
  logic [`CORE_XLEN-1:0] pc_q;
  logic [`CORE_XLEN-1:0] pc_next;
  logic                  wfi_q;
  logic                  early_req;

  assign pc_next = pc_q + `CORE_XLEN'(4);

  // Next request goes out in the retire cycle, except after WFI
  assign early_req = (state_q == StWaitRetire) & retire_done_i & ~wfi_q;

  // No request while the clock enable is low
  assign instr_req_o  = core_en_i & ((state_q == StReq) | early_req);
  assign instr_addr_o = (state_q == StWaitRetire) ? pc_next : pc_q;

  // Word is handed on in the read-valid cycle
  assign instr_word_o  = instr_rdata_i;
  assign instr_valid_o = (state_q == StWaitData) & instr_rvalid_i;
  assign pc_o          = pc_q;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      StReq: begin
        if (instr_req_o && instr_gnt_i) state_d = StWaitData;
      end
      StWaitData: begin
        if (instr_rvalid_i) state_d = StWaitRetire;
      end
      StWaitRetire: begin
        if (retire_done_i) begin
          state_d = (early_req && instr_gnt_i) ? StWaitData : StReq;
        end
      end
      default: state_d = StReq;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= StReq;
      pc_q    <= boot_addr_i;
      wfi_q   <= 1'b0;
    end else if (core_en_i) begin
      state_q <= state_d;
      if (instr_valid_o) wfi_q <= (instr_rdata_i == `CORE_INSTR_WFI);
      if ((state_q == StWaitRetire) && retire_done_i) pc_q <= pc_next;
    end
  end

endmodule

`default_nettype wire

// ==== logic/reg_result.sv ====
/*
 * Result stage: register file with two read ports, write-back
 * and the registered retire trace and completion pulses
 */

`timescale 1ns/1ns
`default_nettype none

`include "core_defines.svh"

module reg_result (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    core_en_i,
  input  logic                    instr_valid_i,
  input  core_pkg::instr_u        instr_word_i,
  input  logic [`CORE_XLEN-1:0]   pc_i,
  input  logic [`CORE_REG_AW-1:0] rs1_addr_i,
  input  logic [`CORE_REG_AW-1:0] rs2_addr_i,
  input  logic [`CORE_REG_AW-1:0] rd_addr_i,
  input  logic [`CORE_XLEN-1:0]   result_i,
  input  logic                    legal_i,
  input  logic                    wfi_i,
  output logic [`CORE_XLEN-1:0]   rs1_data_o,
  output logic [`CORE_XLEN-1:0]   rs2_data_o,
  output logic                    retire_done_o,
  output logic                    wfi_retire_o,
  output logic                    retire_valid_o,
  output logic [`CORE_XLEN-1:0]   retire_pc_o,
  output logic [`CORE_XLEN-1:0]   retire_instr_o,
  output logic [`CORE_REG_AW-1:0] retire_rd_o,
  output logic [`CORE_XLEN-1:0]   retire_wdata_o
);

  import core_pkg::*;

  // x0 has no storage
  logic [`CORE_XLEN-1:0]   rf_q [1:`CORE_NUM_REGS-1];
  logic                    rf_we;
  logic                    retire_done_q;
  logic                    wfi_retire_q;
  logic                    retire_valid_q;
  logic [`CORE_XLEN-1:0]   retire_pc_q;
  instr_u                  retire_instr_q;
  logic [`CORE_REG_AW-1:0] retire_rd_q;
  logic [`CORE_XLEN-1:0]   retire_wdata_q;

  assign rf_we = instr_valid_i & legal_i & ~wfi_i & (rd_addr_i != '0);

  always_ff @(posedge clk_i) begin
    if (core_en_i && rf_we) rf_q[rd_addr_i] <= result_i;
  end

  assign rs1_data_o = (rs1_addr_i == '0) ? '0 : rf_q[rs1_addr_i];
  assign rs2_data_o = (rs2_addr_i == '0) ? '0 : rf_q[rs2_addr_i];

  ////////////////////////////////////////////////////////////////////////////
  // Retire trace
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      retire_done_q  <= 1'b0;
      wfi_retire_q   <= 1'b0;
      retire_valid_q <= 1'b0;
    end else if (core_en_i) begin
      retire_done_q  <= instr_valid_i;
      wfi_retire_q   <= instr_valid_i & wfi_i;
      retire_valid_q <= instr_valid_i & legal_i;
    end
  end

  // Discarded writes show zero data
  always_ff @(posedge clk_i) begin
    if (core_en_i && instr_valid_i) begin
      retire_pc_q    <= pc_i;
      retire_instr_q <= instr_word_i;
      retire_rd_q    <= wfi_i ? '0 : rd_addr_i;
      retire_wdata_q <= rf_we ? result_i : '0;
    end
  end

  assign retire_done_o  = retire_done_q;
  assign wfi_retire_o   = wfi_retire_q;
  assign retire_valid_o = retire_valid_q;
  assign retire_pc_o    = retire_pc_q;
  assign retire_instr_o = retire_instr_q;
  assign retire_rd_o    = retire_rd_q;
  assign retire_wdata_o = retire_wdata_q;

endmodule

`default_nettype wire

// ==== logic/sleep_ctrl.sv ====
/*
 * Sleep controller: latches fetch enable, tracks core busy
 * across WFI and interrupt, drives the core clock enable
 */

`timescale 1ns/1ns
`default_nettype none

module sleep_ctrl (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic fetch_enable_i,
  input  logic irq_i,
  input  logic wfi_retire_i,
  output logic core_en_o,
  output logic core_sleep_o
);

  logic fetch_enable_q;
  logic core_busy_q;
  logic core_en;

  // Set once, held until reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fetch_enable_q <= 1'b0;
    end else if (fetch_enable_i) begin
      fetch_enable_q <= 1'b1;
    end
  end

  // Busy out of reset, idle after WFI until an interrupt
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      core_busy_q <= 1'b1;
    end else if (irq_i) begin
      core_busy_q <= 1'b1;
    end else if (wfi_retire_i) begin
      core_busy_q <= 1'b0;
    end
  end

  assign core_en      = fetch_enable_q & (core_busy_q | irq_i);
  assign core_en_o    = core_en;
  assign core_sleep_o = ~core_en;

endmodule

`default_nettype wire

// ==== tests/tb_core_tests.svh ====
/*
 * Directed core tests that each build a program ending in WFI,
 * start the core and check every retire against the model
 */

// Sleep until fetch enable, then boot from boot_addr_i
task automatic test_boot();
  string name;
  int    err0;
  name = "boot";
  err0 = errors;
  emit_i(F3_ADD, 5'd1, 5'd0, 12'h011);
  emit_i(F3_ADD, 5'd2, 5'd1, 12'h7ff);
  emit_wfi();
  repeat (20) begin
    @(negedge clk_i);
    checks += 2;
    assert (core_sleep_o == 1'b1)
      else fail_value(name, "core_sleep_o", 32'h1, 32'(core_sleep_o));
    assert (instr_req_o == 1'b0)
      else fail_value(name, "instr_req_o", 32'h0, 32'(instr_req_o));
  end
  fetch_q.delete();
  fetch_enable_i = 1'b1;
  @(negedge clk_i);
  fetch_enable_i = 1'b0;
  wait_fetch(name, BOOT_ADDR);
  run_program(name);
  report_test(name, err0);
endtask

task automatic test_imm_chain();
  string name;
  int    err0;
  name = "imm_chain";
  err0 = errors;
  repeat (3) begin
    emit_i(F3_ADD, 5'd1, 5'd1, rand_imm());
    emit_i(F3_XOR, 5'd2, 5'd1, rand_imm());
    emit_i(F3_OR,  5'd3, 5'd2, rand_imm());
    emit_i(F3_AND, 5'd4, 5'd3, rand_imm());
  end
  emit_wfi();
  wake(name);
  run_program(name);
  report_test(name, err0);
endtask

task automatic test_reg_ops();
  string name;
  int    err0;
  name = "reg_ops";
  err0 = errors;
  for (int r = 5; r <= 10; r++) begin
    emit_i(F3_ADD, 5'(r), 5'd0, rand_imm());
  end
  emit_r(7'h00,  F3_ADD, 5'd11, 5'd5,  5'd6);
  emit_r(F7_SUB, F3_ADD, 5'd12, 5'd7,  5'd8);
  emit_r(7'h00,  F3_AND, 5'd13, 5'd9,  5'd10);
  emit_r(7'h00,  F3_OR,  5'd14, 5'd5,  5'd8);
  emit_r(7'h00,  F3_XOR, 5'd15, 5'd6,  5'd9);
  emit_r(7'h00,  F3_SLT, 5'd16, 5'd7,  5'd10);
  emit_r(7'h00,  F3_SLT, 5'd17, 5'd10, 5'd7);
  // Signed compare of -5 against 3
  emit_i(F3_ADD, 5'd18, 5'd0, 12'hffb);
  emit_i(F3_ADD, 5'd19, 5'd0, 12'h003);
  emit_r(7'h00,  F3_SLT, 5'd20, 5'd18, 5'd19);
  emit_r(7'h00,  F3_SLT, 5'd21, 5'd19, 5'd18);
  emit_r(7'h00,  F3_SLT, 5'd22, 5'd18, 5'd18);
  emit_r(F7_SUB, F3_ADD, 5'd23, 5'd19, 5'd18);
  emit_wfi();
  wake(name);
  run_program(name);
  report_test(name, err0);
endtask

task automatic test_x0();
  string name;
  int    err0;
  name = "x0_writes";
  err0 = errors;
  emit_i(F3_ADD, 5'd0, 5'd0, 12'h123);
  emit_r(7'h00,  F3_ADD, 5'd0, 5'd1, 5'd2);
  emit_i(F3_XOR, 5'd0, 5'd3, 12'h7ff);
  emit_i(F3_ADD, 5'd24, 5'd0, 12'h005);
  emit_r(7'h00,  F3_OR,  5'd25, 5'd0, 5'd1);
  emit_r(F7_SUB, F3_ADD, 5'd26, 5'd0, 5'd0);
  emit_wfi();
  wake(name);
  run_program(name);
  report_test(name, err0);
endtask

task automatic test_wfi_wake();
  string       name;
  int          err0;
  logic [31:0] wfi_pc;
  name = "wfi_wake";
  err0 = errors;
  emit_i(F3_ADD, 5'd27, 5'd0, 12'h0c3);
  wfi_pc = next_pc;
  emit_wfi();
  emit_i(F3_ADD, 5'd28, 5'd27, 12'h001);
  emit_wfi();
  wake(name);
  check_next(name);
  check_next(name);
  wait_sleep(name);
  // Nothing may move while irq_i stays low
  repeat (15) begin
    @(negedge clk_i);
    checks += 2;
    assert (instr_req_o == 1'b0)
      else fail_value(name, "instr_req_o", 32'h0, 32'(instr_req_o));
    assert (retire_valid_o == 1'b0)
      else fail_value(name, "retire_valid_o", 32'h0, 32'(retire_valid_o));
  end
  wake(name);
  wait_fetch(name, wfi_pc + 32'd4);
  run_program(name);
  report_test(name, err0);
endtask

task automatic test_illegal();
  string name;
  int    err0;
  name = "illegal";
  err0 = errors;
  emit_i(F3_ADD, 5'd29, 5'd0, 12'h0a5);
  put_word(32'hffff_ffff);
  emit_i(F3_ADD, 5'd30, 5'd29, 12'h001);
  // MUL encoding and ECALL are outside the subset
  put_word({7'h01, 5'd2, 5'd1, F3_ADD, 5'd29, OPC_OP});
  put_word(32'h0000_0073);
  emit_r(7'h00, F3_ADD, 5'd31, 5'd29, 5'd30);
  emit_wfi();
  wake(name);
  run_program(name);
  report_test(name, err0);
endtask

// ==== tests/tb_core_top.sv ====
/*
 * Core testbench with clock, reset, an instruction memory model with
 * random grant and data latency, a reference register file and the tests
 */

`timescale 1ns/1ns
`default_nettype none

module tb_core_top;

  localparam logic [31:0] BOOT_ADDR  = 32'h0000_0080;
  localparam logic [6:0]  OPC_OP     = 7'h33;
  localparam logic [6:0]  OPC_IMM    = 7'h13;
  localparam logic [31:0] WFI_WORD   = 32'h1050_0073;
  localparam logic [2:0]  F3_ADD     = 3'b000;
  localparam logic [2:0]  F3_SLT     = 3'b010;
  localparam logic [2:0]  F3_XOR     = 3'b100;
  localparam logic [2:0]  F3_OR      = 3'b110;
  localparam logic [2:0]  F3_AND     = 3'b111;
  localparam logic [6:0]  F7_SUB     = 7'h20;
  localparam int          WAIT_LIMIT = 100;

  logic        clk_i;
  logic        rst_ni;
  logic        fetch_enable_i;
  logic [31:0] boot_addr_i;
  logic        irq_i;
  logic        instr_gnt_i;
  logic        instr_rvalid_i;
  logic [31:0] instr_rdata_i;
  logic        instr_req_o;
  logic [31:0] instr_addr_o;
  logic        core_sleep_o;
  logic        retire_valid_o;
  logic [31:0] retire_pc_o;
  logic [31:0] retire_instr_o;
  logic [4:0]  retire_rd_o;
  logic [31:0] retire_wdata_o;

  integer      seed;
  int          errors;
  int          checks;
  logic [31:0] mem [0:255];
  logic [31:0] regs [0:31];
  logic [31:0] next_pc;
  logic [31:0] fetch_q [$];
  logic [31:0] exp_pc_q [$];
  logic [31:0] exp_word_q [$];
  logic [31:0] exp_wd_q [$];
  logic [4:0]  exp_rd_q [$];

  core_top i_core_top (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .fetch_enable_i (fetch_enable_i),
    .boot_addr_i    (boot_addr_i),
    .irq_i          (irq_i),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .core_sleep_o   (core_sleep_o),
    .retire_valid_o (retire_valid_o),
    .retire_pc_o    (retire_pc_o),
    .retire_instr_o (retire_instr_o),
    .retire_rd_o    (retire_rd_o),
    .retire_wdata_o (retire_wdata_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  task automatic abort_run(input string what);
    errors++;
    $display("Timeout: %s", what);
    $display("ERRORS FOUND");
    $finish;
  endtask

  task automatic fail_value(input string name, input string what,
                            input logic [31:0] exp, input logic [31:0] act);
    $display("[FAIL] %s: %s expected %h, actual %h", name, what, exp, act);
    errors++;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Instruction memory model
  ////////////////////////////////////////////////////////////////////////////

  task automatic serve_memory();
    logic [31:0] pend_addr;
    logic        pend_valid;
    int          data_wait;
    int          gnt_wait;
    pend_addr  = '0;
    pend_valid = 1'b0;
    data_wait  = 0;
    gnt_wait   = 0;
    forever begin
      @(posedge clk_i);
      if (instr_req_o && instr_gnt_i) begin
        fetch_q.push_back(instr_addr_o);
        pend_addr  = instr_addr_o;
        pend_valid = 1'b1;
        data_wait  = 1 + ($unsigned($random(seed)) % 3);
        gnt_wait   = $unsigned($random(seed)) % 4;
      end
      @(negedge clk_i);
      instr_rvalid_i = 1'b0;
      if (pend_valid) begin
        instr_gnt_i = 1'b0;
        data_wait   = data_wait - 1;
        if (data_wait == 0) begin
          instr_rvalid_i = 1'b1;
          instr_rdata_i  = mem[pend_addr[9:2]];
          pend_valid     = 1'b0;
        end
      end else if (gnt_wait > 0) begin
        instr_gnt_i = 1'b0;
        gnt_wait    = gnt_wait - 1;
      end else begin
        instr_gnt_i = 1'b1;
      end
    end
  endtask

  task automatic fill_memory();
    for (int i = 0; i < 256; i++) begin
      mem[i] = 32'hC0DE_0000 | (32'(i) << 2);
    end
  endtask

  task automatic put_word(input logic [31:0] word);
    mem[next_pc[9:2]] = word;
    next_pc = next_pc + 32'd4;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Reference model and program builder
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] model_alu(input logic [6:0] f7, input logic [2:0] f3,
                                            input logic [31:0] a, input logic [31:0] b);
    case (f3)
      F3_ADD:  return (f7 == F7_SUB) ? a - b : a + b;
      F3_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      F3_XOR:  return a ^ b;
      F3_OR:   return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic [11:0] rand_imm();
    logic [31:0] v;
    v = $random(seed);
    return v[11:0];
  endfunction

  // Expected retire for the word placed at next_pc
  task automatic push_expect(input logic [31:0] word, input logic [4:0] rd,
                             input logic [31:0] res);
    exp_pc_q.push_back(next_pc);
    exp_word_q.push_back(word);
    exp_rd_q.push_back(rd);
    exp_wd_q.push_back((rd == 5'd0) ? 32'h0 : res);
    put_word(word);
  endtask

  task automatic emit_r(input logic [6:0] f7, input logic [2:0] f3, input logic [4:0] rd,
                        input logic [4:0] rs1, input logic [4:0] rs2);
    logic [31:0] res;
    res = model_alu(f7, f3, regs[rs1], regs[rs2]);
    push_expect({f7, rs2, rs1, f3, rd, OPC_OP}, rd, res);
    if (rd != 5'd0) regs[rd] = res;
  endtask

  task automatic emit_i(input logic [2:0] f3, input logic [4:0] rd,
                        input logic [4:0] rs1, input logic [11:0] imm);
    logic [31:0] res;
    res = model_alu(7'h00, f3, regs[rs1], {{20{imm[11]}}, imm});
    push_expect({imm, rs1, f3, rd, OPC_IMM}, rd, res);
    if (rd != 5'd0) regs[rd] = res;
  endtask

  task automatic emit_wfi();
    push_expect(WFI_WORD, 5'd0, 32'h0);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Waits and checks
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_next(input string name);
    logic [31:0] e_pc;
    logic [31:0] e_word;
    logic [31:0] e_wd;
    logic [4:0]  e_rd;
    int          cnt;
    e_pc   = exp_pc_q.pop_front();
    e_word = exp_word_q.pop_front();
    e_wd   = exp_wd_q.pop_front();
    e_rd   = exp_rd_q.pop_front();
    cnt    = 0;
    do begin
      @(negedge clk_i);
      cnt++;
    end while (!retire_valid_o && cnt < WAIT_LIMIT);
    if (!retire_valid_o) begin
      abort_run($sformatf("%s: retire of pc %h never came", name, e_pc));
    end else begin
      checks += 4;
      assert (retire_pc_o == e_pc) else fail_value(name, "retire_pc_o", e_pc, retire_pc_o);
      assert (retire_instr_o == e_word)
        else fail_value(name, "retire_instr_o", e_word, retire_instr_o);
      assert (retire_rd_o == e_rd)
        else fail_value(name, "retire_rd_o", 32'(e_rd), 32'(retire_rd_o));
      assert (retire_wdata_o == e_wd)
        else fail_value(name, "retire_wdata_o", e_wd, retire_wdata_o);
    end
  endtask

  task automatic wait_sleep(input string name);
    int cnt;
    cnt = 0;
    do begin
      @(negedge clk_i);
      cnt++;
    end while (!core_sleep_o && cnt < WAIT_LIMIT);
    if (!core_sleep_o) abort_run($sformatf("%s: core never went to sleep", name));
  endtask

  task automatic wait_fetch(input string name, input logic [31:0] exp_addr);
    int cnt;
    cnt = 0;
    while (fetch_q.size() == 0 && cnt < WAIT_LIMIT) begin
      @(negedge clk_i);
      cnt++;
    end
    if (fetch_q.size() == 0) begin
      abort_run($sformatf("%s: no fetch request was granted", name));
    end else begin
      checks++;
      assert (fetch_q[0] == exp_addr)
        else fail_value(name, "fetch address", exp_addr, fetch_q[0]);
    end
  endtask

  // One-cycle interrupt pulse that must wake the core at once
  task automatic wake(input string name);
    @(negedge clk_i);
    fetch_q.delete();
    irq_i = 1'b1;
    #1;
    checks++;
    assert (core_sleep_o == 1'b0)
      else fail_value(name, "core_sleep_o", 32'h0, 32'(core_sleep_o));
    @(negedge clk_i);
    irq_i = 1'b0;
  endtask

  task automatic run_program(input string name);
    while (exp_pc_q.size() > 0) check_next(name);
    wait_sleep(name);
  endtask

  task automatic report_test(input string name, input int err0);
    $display("Test %s finished: %0d errors", name, errors - err0);
  endtask

  `include "tb_core_tests.svh"

  initial begin
    #4_000_000;
    abort_run("watchdog expired before the test sequence ended");
  end

  initial begin
    seed           = 54;
    errors         = 0;
    checks         = 0;
    rst_ni         = 1'b0;
    fetch_enable_i = 1'b0;
    irq_i          = 1'b0;
    boot_addr_i    = BOOT_ADDR;
    instr_gnt_i    = 1'b0;
    instr_rvalid_i = 1'b0;
    instr_rdata_i  = '0;
    next_pc        = BOOT_ADDR;
    foreach (regs[r]) regs[r] = '0;
    fill_memory();
    fork
      serve_memory();
    join_none
    repeat (4) @(negedge clk_i);
    rst_ni = 1'b1;
    test_boot();
    test_imm_chain();
    test_reg_ops();
    test_x0();
    test_wfi_wake();
    test_illegal();
    $display("Tests: 6, checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+logic
+incdir+tests
logic/core_pkg.sv
logic/sleep_ctrl.sv
logic/instr_fetch.sv
logic/instr_decode.sv
logic/alu_execute.sv
logic/reg_result.sv
logic/core_top.sv
tests/tb_core_top.sv
